/* common/sd_pkg.sv */
package sd_pkg;

    // ==============================
    // Frame geometry
    // ==============================

    // Start, direction, index, argument, CRC, end
    localparam int CMD_FRAME_BITS = 48;

    // Portion of the frame covered by the CRC
    localparam int CMD_BODY_BITS = 40;

    // Wide enough to count every bit of a frame
    localparam int BIT_CNT_W = $clog2(CMD_FRAME_BITS);

    // ==============================
    // CRC7, x^7 + x^3 + 1
    // ==============================
    localparam int CRC7_BITS = 7;
    localparam logic [CRC7_BITS-1:0] CRC7_POLY = 7'h09;

    // Card clocks after the host releases the line before input is trusted
    localparam int TURNAROUND_TICKS = 3;

    typedef enum logic [1:0] {
        RESP_NONE = 2'b00,
        RESP_48   = 2'b01
    } resp_type_e;

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_BODY,
        CMD_CRC,
        CMD_END
    } cmd_state_e;

    typedef enum logic [2:0] {
        RESP_IDLE,
        RESP_WAIT_START,
        RESP_BODY,
        RESP_CRC,
        RESP_END
    } resp_state_e;

endpackage

/* common/sd_bit_if.sv */
`timescale 1ns/1ps

// Bit-level link between the line driver and the command/response framers
interface sd_bit_if;

    logic tick;
    logic tx_bit;
    logic tx_en;
    logic rx_bit;
    logic rx_valid;

    modport phy (
        output tick,
        output rx_bit,
        output rx_valid,
        input  tx_bit,
        input  tx_en
    );

    modport sender (
        input  tick,
        output tx_bit,
        output tx_en
    );

    modport receiver (
        input  tick,
        input  rx_bit,
        input  rx_valid
    );

endinterface

/* verilog/sd_crc7.sv */
`timescale 1ns/1ps

module sd_crc7 (
    input  logic clk_fast,
    input  logic clear,
    input  logic enable,
    input  logic shift_out,
    input  logic din,
    output logic crc_bit
);

    localparam int MSB = sd_pkg::CRC7_BITS - 1;

    logic [MSB:0] crc;
    logic         feedback;

    assign feedback = din ^ crc[MSB];

    // Remainder leaves MSB first
    assign crc_bit = crc[MSB];

    always_ff @(posedge clk_fast) begin
        if (clear) begin
            crc <= '0;
        end else if (enable) begin
            if (shift_out) begin
                // Just walk the remainder out
                crc <= {crc[MSB-1:0], 1'b0};
            end else begin
                crc <= {crc[MSB-1:0], 1'b0} ^ (feedback ? sd_pkg::CRC7_POLY : '0);
            end
        end
    end

endmodule

/* verilog/sd_cmd_phy.sv */
`timescale 1ns/1ps

module sd_cmd_phy #(
    parameter int CLK_DIV = 4
) (
    input  logic  clk_fast,
    input  logic  init_resetPulse,
    sd_bit_if.phy bus,
    output logic  sd_clk,
    output logic  cmd_out,
    output logic  cmd_oe,
    input  logic  cmd_in
);

    localparam int HALF  = CLK_DIV / 2;
    localparam int CNT_W = $clog2(CLK_DIV);
    localparam int TA    = sd_pkg::TURNAROUND_TICKS;

    logic [CNT_W-1:0] div_cnt;
    logic             rise_evt;
    logic             fall_evt;
    logic [TA-1:0]    active;
    logic             cmd_in_q;

    // ==============================
    // Card clock divider
    // ==============================
    assign rise_evt = (div_cnt == CNT_W'(CLK_DIV - 1));
    assign fall_evt = (div_cnt == CNT_W'(HALF - 1));

    // Framers advance on the same edge the card clock goes high
    assign bus.tick = rise_evt;

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            div_cnt <= '0;
            sd_clk  <= 1'b0;
        end else begin
            div_cnt <= rise_evt ? '0 : div_cnt + 1'b1;
            if (rise_evt) begin
                sd_clk <= 1'b1;
            end else if (fall_evt) begin
                sd_clk <= 1'b0;
            end
        end
    end

    // ==============================
    // Command line output
    // ==============================
    // Launch on the falling half so the card sees a stable bit at the rise
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            cmd_out <= 1'b1;
            cmd_oe  <= 1'b0;
        end else if (fall_evt) begin
            cmd_out <= bus.tx_en ? bus.tx_bit : 1'b1;
            cmd_oe  <= bus.tx_en;
        end
    end

    // ==============================
    // Turnaround and input sampling
    // ==============================
    // One bit per card clock, set while we were driving
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            active   <= '0;
            cmd_in_q <= 1'b1;
        end else begin
            cmd_in_q <= cmd_in;
            if (rise_evt) begin
                active <= {active[TA-2:0], bus.tx_en};
            end
        end
    end

    assign bus.rx_valid = !bus.tx_en && (active == '0);

    // Line reads as idle high until the card can own it
    assign bus.rx_bit = bus.rx_valid ? cmd_in_q : 1'b1;

endmodule

/* sd_cmd/sd_cmd_sender.sv */
`timescale 1ns/1ps

module sd_cmd_sender (
    input  logic                              clk_fast,
    input  logic                              init_resetPulse,
    input  logic                              start,
    input  logic [sd_pkg::CMD_BODY_BITS-1:0]  cmd_data,
    input  sd_pkg::resp_type_e                resp_type,
    sd_bit_if.sender                          bus,
    output logic                              done,
    output logic                              resp_start
);

    localparam int CNT_W = sd_pkg::BIT_CNT_W;
    localparam int MSB   = sd_pkg::CMD_BODY_BITS - 1;
    localparam logic [CNT_W-1:0] LAST_BODY = CNT_W'(sd_pkg::CMD_BODY_BITS - 1);
    localparam logic [CNT_W-1:0] LAST_CRC  = CNT_W'(sd_pkg::CRC7_BITS - 1);

    sd_pkg::cmd_state_e state;
    sd_pkg::resp_type_e resp_type_q;
    logic               start_pend;
    logic               accept;
    logic [CNT_W-1:0]   bit_cnt;
    logic [MSB:0]       body_q;
    logic               crc_en;
    logic               crc_shift;
    logic               crc_bit;

    // Triggers during a command are dropped
    assign accept    = start && (state == sd_pkg::CMD_IDLE) && !start_pend;
    assign crc_en    = bus.tick && (state == sd_pkg::CMD_BODY || state == sd_pkg::CMD_CRC);
    assign crc_shift = (state == sd_pkg::CMD_CRC);

    // Receiver is armed together with the tick that sends the end bit
    assign resp_start = bus.tick && (state == sd_pkg::CMD_END)
                        && (resp_type_q == sd_pkg::RESP_48);

    assign bus.tx_en = (state != sd_pkg::CMD_IDLE);

    always_comb begin
        case (state)
            sd_pkg::CMD_BODY: bus.tx_bit = body_q[MSB];
            sd_pkg::CMD_CRC:  bus.tx_bit = crc_bit;
            default:          bus.tx_bit = 1'b1;
        endcase
    end

    // Command payload
    always_ff @(posedge clk_fast) begin
        if (accept) begin
            body_q      <= cmd_data;
            resp_type_q <= resp_type;
        end else if (bus.tick && state == sd_pkg::CMD_BODY) begin
            body_q <= {body_q[MSB-1:0], 1'b0};
        end
    end

    // ==============================
    // Frame sequencer
    // ==============================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state      <= sd_pkg::CMD_IDLE;
            start_pend <= 1'b0;
            bit_cnt    <= '0;
            done       <= 1'b0;
        end else begin
            if (accept) begin
                start_pend <= 1'b1;
            end
            case (state)
                sd_pkg::CMD_IDLE: begin
                    // Align the first bit to a full card clock
                    if (start_pend && bus.tick) begin
                        start_pend <= 1'b0;
                        bit_cnt    <= '0;
                        state      <= sd_pkg::CMD_BODY;
                    end
                end
                sd_pkg::CMD_BODY: begin
                    if (bus.tick) begin
                        if (bit_cnt == LAST_BODY) begin
                            bit_cnt <= '0;
                            state   <= sd_pkg::CMD_CRC;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                sd_pkg::CMD_CRC: begin
                    if (bus.tick) begin
                        if (bit_cnt == LAST_CRC) begin
                            state <= sd_pkg::CMD_END;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                sd_pkg::CMD_END: begin
                    if (bus.tick) begin
                        done  <= ~done;
                        state <= sd_pkg::CMD_IDLE;
                    end
                end
                default: state <= sd_pkg::CMD_IDLE;
            endcase
        end
    end

    sd_crc7 u_sd_crc7 (
        .clk_fast  (clk_fast),
        .clear     (accept),
        .enable    (crc_en),
        .shift_out (crc_shift),
        .din       (body_q[MSB]),
        .crc_bit   (crc_bit)
    );

endmodule

/* sd_cmd/sd_resp_receiver.sv */
`timescale 1ns/1ps

module sd_resp_receiver (
    input  logic                               clk_fast,
    input  logic                               init_resetPulse,
    input  logic                               resp_start,
    sd_bit_if.receiver                         bus,
    output logic                               resp_done,
    output logic [sd_pkg::CMD_FRAME_BITS-1:0]  resp_data,
    output logic                               resp_crc_err
);

    localparam int CNT_W = sd_pkg::BIT_CNT_W;
    localparam int SH_W  = sd_pkg::CMD_FRAME_BITS - 1;
    localparam logic [CNT_W-1:0] LAST_BODY = CNT_W'(sd_pkg::CMD_BODY_BITS - 1);
    localparam logic [CNT_W-1:0] LAST_CRC  = CNT_W'(sd_pkg::CRC7_BITS - 1);

    sd_pkg::resp_state_e state;
    logic [CNT_W-1:0]    bit_cnt;
    logic [SH_W-1:0]     shift_q;
    logic                start_seen;
    logic                bit_take;
    logic                crc_en;
    logic                crc_shift;
    logic                crc_bit;

    // First valid low bit after the turnaround
    assign start_seen = bus.tick && bus.rx_valid && !bus.rx_bit
                        && (state == sd_pkg::RESP_WAIT_START);

    assign bit_take = start_seen
                      || (bus.tick && (state == sd_pkg::RESP_BODY || state == sd_pkg::RESP_CRC));

    // CRC covers start bit and body only
    assign crc_en    = bit_take;
    assign crc_shift = (state == sd_pkg::RESP_CRC);

    // ==============================
    // Capture path
    // ==============================
    always_ff @(posedge clk_fast) begin
        if (bit_take) begin
            shift_q <= {shift_q[SH_W-2:0], bus.rx_bit};
        end
        if (bus.tick && state == sd_pkg::RESP_END) begin
            resp_data <= {shift_q, bus.rx_bit};
        end
    end

    // ==============================
    // Response FSM
    // ==============================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state        <= sd_pkg::RESP_IDLE;
            bit_cnt      <= '0;
            resp_done    <= 1'b0;
            resp_crc_err <= 1'b0;
        end else if (resp_start) begin
            state        <= sd_pkg::RESP_WAIT_START;
            resp_crc_err <= 1'b0;
        end else begin
            case (state)
                sd_pkg::RESP_IDLE: begin
                end
                sd_pkg::RESP_WAIT_START: begin
                    // Card latency is open ended
                    if (start_seen) begin
                        bit_cnt <= CNT_W'(1);
                        state   <= sd_pkg::RESP_BODY;
                    end
                end
                sd_pkg::RESP_BODY: begin
                    if (bus.tick) begin
                        if (bit_cnt == LAST_BODY) begin
                            bit_cnt <= '0;
                            state   <= sd_pkg::RESP_CRC;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                sd_pkg::RESP_CRC: begin
                    if (bus.tick) begin
                        // Compare bit by bit against our remainder
                        if (bus.rx_bit != crc_bit) begin
                            resp_crc_err <= 1'b1;
                        end
                        if (bit_cnt == LAST_CRC) begin
                            state <= sd_pkg::RESP_END;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                sd_pkg::RESP_END: begin
                    if (bus.tick) begin
                        if (!bus.rx_bit) begin
                            resp_crc_err <= 1'b1;
                        end
                        resp_done <= ~resp_done;
                        state     <= sd_pkg::RESP_IDLE;
                    end
                end
                default: state <= sd_pkg::RESP_IDLE;
            endcase
        end
    end

    sd_crc7 u_sd_crc7 (
        .clk_fast  (clk_fast),
        .clear     (resp_start),
        .enable    (crc_en),
        .shift_out (crc_shift),
        .din       (bus.rx_bit),
        .crc_bit   (crc_bit)
    );

endmodule

/* verilog/sd_cmd_ctrl.sv */
`timescale 1ns/1ps

module sd_cmd_ctrl #(
    parameter int CLK_DIV = 4
) (
    input  logic                               clk_fast,
    input  logic                               init_resetPulse,

    // Host command side, toggle handshake
    input  logic                               cmd_trigger,
    input  logic [sd_pkg::CMD_BODY_BITS-1:0]   cmd_data,
    input  sd_pkg::resp_type_e                 cmd_resp_type,
    output logic                               cmd_done,

    // Host response side
    output logic                               resp_done,
    output logic [sd_pkg::CMD_FRAME_BITS-1:0]  resp_data,
    output logic                               resp_crc_err,

    // Card side
    output logic                               sd_clk,
    output logic                               cmd_out,
    output logic                               cmd_oe,
    input  logic                               cmd_in
);

    logic [2:0] trig_sync;
    logic       start_pulse;
    logic       resp_start;

    sd_bit_if u_bit_if ();

    // ==============================
    // Trigger synchronizer
    // ==============================
    // Two flops for metastability, third for edge detect
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            trig_sync <= '0;
        end else begin
            trig_sync <= {trig_sync[1:0], cmd_trigger};
        end
    end

    // Either edge of the toggle starts a command
    assign start_pulse = trig_sync[2] ^ trig_sync[1];

    sd_cmd_phy #(
        .CLK_DIV (CLK_DIV)
    ) u_sd_cmd_phy (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .bus             (u_bit_if),
        .sd_clk          (sd_clk),
        .cmd_out         (cmd_out),
        .cmd_oe          (cmd_oe),
        .cmd_in          (cmd_in)
    );

    sd_cmd_sender u_sd_cmd_sender (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .start           (start_pulse),
        .cmd_data        (cmd_data),
        .resp_type       (cmd_resp_type),
        .bus             (u_bit_if),
        .done            (cmd_done),
        .resp_start      (resp_start)
    );

    sd_resp_receiver u_sd_resp_receiver (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .resp_start      (resp_start),
        .bus             (u_bit_if),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err)
    );

endmodule

/* dv/sd_cmd_checker.sv */
`timescale 1ns/1ps

module sd_cmd_checker (
    input  logic               clk_fast,

    // DUT ports under observation
    input  logic               sd_clk,
    input  logic               cmd_out,
    input  logic               cmd_oe,
    input  logic               cmd_done,
    input  logic               resp_done,
    input  logic [47:0]        resp_data,
    input  logic               resp_crc_err,

    // Sequencing and expected values from the testbench top
    input  logic               check_reset,
    input  logic               test_begin,
    input  logic               test_end,
    input  int                 test_num,
    input  logic [47:0]        exp_cmd_frame,
    input  sd_pkg::resp_type_e exp_resp_type,
    input  logic [47:0]        exp_resp_frame,
    input  logic               exp_crc_err,
    input  logic               end_of_run,
    output int                 fail_count,
    output logic               summary_ready
);

    localparam int FRAME_BITS = 48;

    int          bit_count   = 0;
    int          done_count  = 0;
    int          resp_count  = 0;
    int          want_resps  = 0;
    int          test_errors = 0;
    int          passes      = 0;
    int          fails       = 0;
    logic        in_test     = 1'b0;
    logic        summary_q   = 1'b0;
    logic [47:0] frame_left  = '0;
    logic        sd_clk_q;
    logic        cmd_done_q;
    logic        resp_done_q;

    assign fail_count    = fails;
    assign summary_ready = summary_q;

    task automatic flag_error(input string msg);
        test_errors++;
        $display("[ERROR] t=%0d ns: %s", $time, msg);
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0) begin
            passes++;
            $display("%s: pass", name);
        end else begin
            fails++;
            $display("%s: FAIL with %0d error(s)", name, test_errors);
        end
    endtask

    // ==============================
    // Sampling, mid clk_fast cycle
    // ==============================
    always @(negedge clk_fast) begin
        if (check_reset) begin
            test_errors = 0;
            if (cmd_oe !== 1'b0) begin
                flag_error($sformatf("cmd_oe is %b after reset, expected 0", cmd_oe));
            end
            if (cmd_out !== 1'b1) begin
                flag_error($sformatf("cmd_out is %b after reset, expected 1", cmd_out));
            end
            if (sd_clk !== 1'b0) begin
                flag_error($sformatf("sd_clk is %b after reset, expected 0", sd_clk));
            end
            if (cmd_done !== 1'b0 || resp_done !== 1'b0) begin
                flag_error($sformatf("done toggles are %b/%b after reset, expected 0/0",
                                     cmd_done, resp_done));
            end
            close_test("reset check");
        end

        if (test_begin) begin
            in_test     = 1'b1;
            bit_count   = 0;
            done_count  = 0;
            resp_count  = 0;
            test_errors = 0;
            frame_left  = exp_cmd_frame;
            want_resps  = (exp_resp_type == sd_pkg::RESP_48) ? 1 : 0;
        end

        if (in_test) begin
            // Card samples cmd_out on the rising card clock
            if (sd_clk === 1'b1 && sd_clk_q === 1'b0 && cmd_oe === 1'b1) begin
                if (bit_count < FRAME_BITS && cmd_out !== frame_left[47]) begin
                    flag_error($sformatf("frame bit %0d is %b, expected %b",
                                         bit_count, cmd_out, frame_left[47]));
                end
                frame_left = frame_left << 1;
                bit_count++;
            end

            if (cmd_done !== cmd_done_q) begin
                done_count++;
                if (bit_count != FRAME_BITS) begin
                    flag_error($sformatf("cmd_done toggled after %0d frame bits, expected %0d",
                                         bit_count, FRAME_BITS));
                end
            end

            if (resp_done !== resp_done_q) begin
                resp_count++;
                if (want_resps == 0) begin
                    flag_error("resp_done toggled for a command with no response");
                end else begin
                    if (resp_data !== exp_resp_frame) begin
                        flag_error($sformatf("resp_data is %h, expected %h",
                                             resp_data, exp_resp_frame));
                    end
                    if (resp_crc_err !== exp_crc_err) begin
                        flag_error($sformatf("resp_crc_err is %b, expected %b",
                                             resp_crc_err, exp_crc_err));
                    end
                end
            end

            if (test_end) begin
                if (bit_count != FRAME_BITS) begin
                    flag_error($sformatf("%0d frame bits driven, expected %0d",
                                         bit_count, FRAME_BITS));
                end
                if (done_count != 1) begin
                    flag_error($sformatf("cmd_done toggled %0d times, expected once", done_count));
                end
                if (resp_count != want_resps) begin
                    flag_error($sformatf("resp_done toggled %0d times, expected %0d",
                                         resp_count, want_resps));
                end
                close_test($sformatf("test %0d", test_num));
                in_test = 1'b0;
            end
        end

        sd_clk_q    = sd_clk;
        cmd_done_q  = cmd_done;
        resp_done_q = resp_done;

        if (end_of_run && !summary_q) begin
            $display("summary: %0d run, %0d passed, %0d failed", passes + fails, passes, fails);
            summary_q = 1'b1;
        end
    end

endmodule

/* dv/tb_sd_cmd_ctrl.sv */
`timescale 1ns/1ps

module tb_sd_cmd_ctrl;

    localparam int CLK_DIV        = 4;
    localparam int CLK_HALF_NS    = 20;
    localparam int RESET_CYCLES   = 3;
    localparam int MEM_AW         = 9;
    localparam int MEM_WORDS      = 1 << MEM_AW;
    localparam int WORDS_PER_TEST = 5;
    localparam int MAX_TESTS      = (MEM_WORDS - 1) / WORDS_PER_TEST;
    localparam int FRAME_BITS     = 48;
    // Falling card clocks from cmd_done to the response start bit
    localparam int RESP_LATENCY   = 5;
    localparam int CARD_CLKS_PER_TEST = 200;

    logic               clk_fast;
    logic               init_resetPulse;
    logic               cmd_trigger;
    logic [39:0]        cmd_data;
    sd_pkg::resp_type_e cmd_resp_type;
    logic               cmd_done;
    logic               resp_done;
    logic [47:0]        resp_data;
    logic               resp_crc_err;
    logic               sd_clk;
    logic               cmd_out;
    logic               cmd_oe;
    logic               cmd_in;

    logic               check_reset;
    logic               test_begin;
    logic               test_end;
    logic               end_of_run;
    int                 test_num;
    logic [47:0]        exp_cmd_frame;
    logic [47:0]        exp_resp_frame;
    sd_pkg::resp_type_e exp_resp_type;
    logic               exp_crc_err;
    int                 fail_count;
    logic               summary_ready;

    logic [47:0]        stim_mem [MEM_WORDS];
    int                 num_tests   = 0;
    logic               stim_loaded = 1'b0;

    initial begin
        clk_fast = 1'b0;
        forever #(CLK_HALF_NS) clk_fast = ~clk_fast;
    end

    sd_cmd_ctrl #(
        .CLK_DIV (CLK_DIV)
    ) u_sd_cmd_ctrl (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_trigger     (cmd_trigger),
        .cmd_data        (cmd_data),
        .cmd_resp_type   (cmd_resp_type),
        .cmd_done        (cmd_done),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err),
        .sd_clk          (sd_clk),
        .cmd_out         (cmd_out),
        .cmd_oe          (cmd_oe),
        .cmd_in          (cmd_in)
    );

    sd_cmd_checker u_sd_cmd_checker (
        .clk_fast       (clk_fast),
        .sd_clk         (sd_clk),
        .cmd_out        (cmd_out),
        .cmd_oe         (cmd_oe),
        .cmd_done       (cmd_done),
        .resp_done      (resp_done),
        .resp_data      (resp_data),
        .resp_crc_err   (resp_crc_err),
        .check_reset    (check_reset),
        .test_begin     (test_begin),
        .test_end       (test_end),
        .test_num       (test_num),
        .exp_cmd_frame  (exp_cmd_frame),
        .exp_resp_type  (exp_resp_type),
        .exp_resp_frame (exp_resp_frame),
        .exp_crc_err    (exp_crc_err),
        .end_of_run     (end_of_run),
        .fail_count     (fail_count),
        .summary_ready  (summary_ready)
    );

    // Serial CRC7 of a 40-bit body with x^7 + x^3 + 1 and MSB first
    function automatic logic [6:0] crc7_calc(input logic [39:0] bits);
        logic [39:0] data;
        logic [6:0]  crc;
        logic        fb;
        data = bits;
        crc  = '0;
        for (int i = 0; i < 40; i++) begin
            fb   = data[39] ^ crc[6];
            crc  = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
            data = data << 1;
        end
        return crc;
    endfunction

    task automatic idle_gap;
        int gap;
        gap = 2 + int'($urandom % 8);
        repeat (gap) @(posedge clk_fast);
        #2;
    endtask

    // Toggle the trigger and wait for the host to finish the frame
    task automatic send_command(input logic [39:0] body, input sd_pkg::resp_type_e rtype);
        @(posedge clk_fast);
        #2;
        cmd_data      = body;
        cmd_resp_type = rtype;
        cmd_trigger   = ~cmd_trigger;
        @(cmd_done);
    endtask

    // ==============================
    // Card responder
    // ==============================
    task automatic card_respond(input logic [47:0] frame);
        logic [47:0] bits;
        bits = frame;
        repeat (RESP_LATENCY - 1) @(negedge sd_clk);
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(negedge sd_clk);
            #2;
            cmd_in = bits[47];
            bits   = bits << 1;
        end
    endtask

    task automatic run_test(input int t);
        logic [47:0]        idx_w;
        logic [47:0]        arg_w;
        logic [47:0]        type_w;
        logic [47:0]        pay_w;
        logic [47:0]        bad_w;
        logic [39:0]        body;
        logic [39:0]        resp_body;
        logic [6:0]         resp_crc;
        sd_pkg::resp_type_e rtype;
        int                 base;
        base   = 1 + t * WORDS_PER_TEST;
        idx_w  = stim_mem[MEM_AW'(base)];
        arg_w  = stim_mem[MEM_AW'(base + 1)];
        type_w = stim_mem[MEM_AW'(base + 2)];
        pay_w  = stim_mem[MEM_AW'(base + 3)];
        bad_w  = stim_mem[MEM_AW'(base + 4)];
        rtype  = type_w[0] ? sd_pkg::RESP_48 : sd_pkg::RESP_NONE;

        // Start bit 0, host direction 1
        body      = {1'b0, 1'b1, idx_w[5:0], arg_w[31:0]};
        resp_body = {2'b00, pay_w[37:0]};
        resp_crc  = crc7_calc(resp_body) ^ {6'b0, bad_w[0]};

        test_num       = t + 1;
        exp_cmd_frame  = {body, crc7_calc(body), 1'b1};
        exp_resp_frame = {resp_body, resp_crc, 1'b1};
        exp_resp_type  = rtype;
        exp_crc_err    = bad_w[0];
        test_begin     = 1'b1;
        @(posedge clk_fast);
        #2;
        test_begin = 1'b0;

        send_command(body, rtype);
        // Card replies even when no response was requested
        card_respond(exp_resp_frame);
        if (rtype == sd_pkg::RESP_48) begin
            @(resp_done);
        end else begin
            // Room for a stray resp_done after the end bit
            repeat (RESP_LATENCY) @(negedge sd_clk);
        end
        idle_gap();

        test_end = 1'b1;
        @(posedge clk_fast);
        #2;
        test_end = 1'b0;
    endtask

    // ==============================
    // Watchdog
    // ==============================
    initial begin
        wait (stim_loaded === 1'b1);
        repeat (num_tests * CARD_CLKS_PER_TEST * CLK_DIV) @(posedge clk_fast);
        $display("watchdog: the tests did not finish within %0d card clocks each",
                 CARD_CLKS_PER_TEST);
        $display("Regression failed");
        $finish;
    end

    initial begin
        init_resetPulse = 1'b1;
        cmd_trigger     = 1'b0;
        cmd_data        = '0;
        cmd_resp_type   = sd_pkg::RESP_NONE;
        cmd_in          = 1'b1;
        check_reset     = 1'b0;
        test_begin      = 1'b0;
        test_end        = 1'b0;
        end_of_run      = 1'b0;
        test_num        = 0;
        exp_cmd_frame   = '0;
        exp_resp_frame  = '0;
        exp_resp_type   = sd_pkg::RESP_NONE;
        exp_crc_err     = 1'b0;
        void'($urandom(32'h17cb));

        $readmemh("dv/sd_cmd_stimulus.txt", stim_mem);
        num_tests = int'(stim_mem[0][15:0]);
        if (num_tests < 1 || num_tests > MAX_TESTS) begin
            $display("stimulus file gives %0d tests, which is not a usable count", num_tests);
            $display("Regression failed");
            $finish;
        end else begin
            stim_loaded = 1'b1;

            repeat (RESET_CYCLES) @(posedge clk_fast);
            #2;
            init_resetPulse = 1'b0;
            check_reset     = 1'b1;
            @(posedge clk_fast);
            #2;
            check_reset = 1'b0;

            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end

            end_of_run = 1'b1;
            wait (summary_ready === 1'b1);
            if (fail_count == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

/* dv/sd_cmd_stimulus.txt */
// Columns: cmd index, argument, resp type (0 none, 1 48-bit), 38-bit reply payload, bad CRC
// The first word is the number of tests, all values in hex
10
00 00000000 0 0000000000 0
08 000001aa 1 08000001aa 0
37 00000000 1 3700000120 0
29 40ff8000 1 3f80ff8000 0
02 00000000 0 0000000000 0
03 00000000 1 0312340500 0
09 12340000 1 0900000700 1
07 12340000 1 0700000700 0
10 00000200 1 1000000900 0
0d 12340000 1 0d00000900 1
11 00001000 1 1100000900 0
0c 00000000 0 0000000000 0
37 12340000 1 3700000920 1
06 00000002 1 0600000920 0
3f ffffffff 1 3fffffffff 0
00 00000000 1 0000000000 0

/* src.f */
common/sd_pkg.sv
common/sd_bit_if.sv
verilog/sd_crc7.sv
verilog/sd_cmd_phy.sv
sd_cmd/sd_cmd_sender.sv
sd_cmd/sd_resp_receiver.sv
verilog/sd_cmd_ctrl.sv
dv/sd_cmd_checker.sv
dv/tb_sd_cmd_ctrl.sv

/* Makefile */
# Verilator build and run of the SD command path testbench

VERILATOR ?= verilator
TOP       ?= tb_sd_cmd_ctrl
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "make test: failure reported in $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "make test: no verdict found in $(LOG)"; exit 1; \
	else \
		echo "make test: ok"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
